// ==== hdl/tile_mem_pkg.sv ====
package tile_mem_pkg;

	//************************************************************
	// Word, byte and address geometry of the tile memory
	//************************************************************
	localparam int DATA_WIDTH = 32;                      // Bus and word width
	localparam int BYTE_WIDTH = 8;                       // One byte lane
	localparam int SEL_WIDTH  = DATA_WIDTH / BYTE_WIDTH; // One select per byte, 4 lanes
	localparam int ADDR_WIDTH = 10;                      // Word address
	localparam int MEM_DEPTH  = 1 << ADDR_WIDTH;         // 1024 words

	// Preload image, read by the RAM at start
	localparam string INIT_FILE = "prog_ram_init.hex";

	//************************************************************
	// Cycle-type tag of the bus
	//************************************************************
	localparam int CTI_WIDTH = 3; // Tag width on the bus

	// Only classic uses the registered acknowledge
	typedef enum logic [CTI_WIDTH-1:0] {
		CTI_CLASSIC     = 3'd0, // Single transfer, registered ack
		CTI_CONST_BURST = 3'd1, // Burst on a fixed address
		CTI_INC_BURST   = 3'd2, // Burst on incrementing addresses
		CTI_END_BURST   = 3'd7  // Last beat of a burst
	} cti_e;

endpackage

// ==== hdl/dual_port_ram.sv ====
`timescale 1ns/1ps

// True dual-port word array, byte-enable writes, registered read-first output
module dual_port_ram (
	input  logic                               clk,
	// Port a, instruction side
	input  logic                               we_a_i,   // Write enable
	input  logic [tile_mem_pkg::SEL_WIDTH-1:0]  be_a_i,   // Byte mask
	input  logic [tile_mem_pkg::ADDR_WIDTH-1:0] addr_a_i, // Word address
	input  logic [tile_mem_pkg::DATA_WIDTH-1:0] data_a_i, // Write data
	output logic [tile_mem_pkg::DATA_WIDTH-1:0] q_a_o,    // Registered read data
	// Port b, data side
	input  logic                               we_b_i,
	input  logic [tile_mem_pkg::SEL_WIDTH-1:0]  be_b_i,
	input  logic [tile_mem_pkg::ADDR_WIDTH-1:0] addr_b_i,
	input  logic [tile_mem_pkg::DATA_WIDTH-1:0] data_b_i,
	output logic [tile_mem_pkg::DATA_WIDTH-1:0] q_b_o
);
	import tile_mem_pkg::*;

	logic [DATA_WIDTH-1:0] mem [0:MEM_DEPTH-1]; // Storage array

	//************************************************************
	// Preload, zeros first so unlisted words read back as 0
	//************************************************************
	initial begin
		for (int w = 0; w < MEM_DEPTH; w++) begin
			mem[w] = '0; // Clear word
		end
		$readmemh(INIT_FILE, mem); // Program image from hex file
	end

	//************************************************************
	// Read and write on the same edge
	//************************************************************
	always @(posedge clk) begin
		q_a_o <= mem[addr_a_i]; // Old word, read-first
		q_b_o <= mem[addr_b_i];
		// Port b lanes first
		for (int i = 0; i < SEL_WIDTH; i++) begin
			if (we_b_i && be_b_i[i]) begin
				mem[addr_b_i][i*BYTE_WIDTH +: BYTE_WIDTH] <=
					data_b_i[i*BYTE_WIDTH +: BYTE_WIDTH]; // Masked byte of b
			end
		end
		// Port a lanes last, so a overrides b on a shared byte
		for (int i = 0; i < SEL_WIDTH; i++) begin
			if (we_a_i && be_a_i[i]) begin
				mem[addr_a_i][i*BYTE_WIDTH +: BYTE_WIDTH] <=
					data_a_i[i*BYTE_WIDTH +: BYTE_WIDTH]; // Masked byte of a
			end
		end
	end

endmodule

// ==== hdl/bus_slave_port.sv ====
`timescale 1ns/1ps

// One bus slave port in front of one side of the RAM
module bus_slave_port (
	input  logic                               clk,
	input  logic                               reset,
	// Bus side
	input  logic [tile_mem_pkg::DATA_WIDTH-1:0] dat_i,   // Write data
	input  logic [tile_mem_pkg::SEL_WIDTH-1:0]  sel_i,   // Byte selects
	input  logic [tile_mem_pkg::ADDR_WIDTH-1:0] addr_i,  // Word address
	input  tile_mem_pkg::cti_e                 cti_i,   // Cycle-type tag
	input  logic                               stb_i,   // Strobe
	input  logic                               we_i,    // Write enable
	output logic [tile_mem_pkg::DATA_WIDTH-1:0] dat_o,   // Read data
	output logic                               ack_o,   // Acknowledge
	// RAM side
	output logic                               ram_we_o,
	output logic [tile_mem_pkg::SEL_WIDTH-1:0]  ram_be_o,
	output logic [tile_mem_pkg::ADDR_WIDTH-1:0] ram_addr_o,
	output logic [tile_mem_pkg::DATA_WIDTH-1:0] ram_data_o,
	input  logic [tile_mem_pkg::DATA_WIDTH-1:0] ram_q_i
);
	import tile_mem_pkg::*;

	logic is_classic;     // Tag asks for the registered ack
	logic ack_classic;    // Registered ack, classic cycles
	logic ack_classic_nx; // Next value of the classic ack
	logic ack_burst;      // Ack that follows the strobe

	//************************************************************
	// Path to the array
	//************************************************************
	assign ram_we_o   = stb_i & we_i; // Write only inside a strobe
	assign ram_be_o   = sel_i;        // Lane mask straight through
	assign ram_addr_o = addr_i;
	assign ram_data_o = dat_i;
	assign dat_o      = ram_q_i;      // Registered in the array already

	//************************************************************
	// Acknowledge generation
	//************************************************************
	assign is_classic = (cti_i == CTI_CLASSIC);
	assign ack_burst  = stb_i; // Master registers the data itself in a burst

	// Set on a strobe while the ack is low, so a held strobe toggles it
	assign ack_classic_nx = stb_i & ~ack_o;

	always_ff @(posedge clk) begin
		if (reset) begin
			ack_classic <= 1'b0; // No ack out of reset
		end else begin
			ack_classic <= ack_classic_nx;
		end
	end

	assign ack_o = is_classic ? ack_classic : ack_burst; // Tag picks the ack source

endmodule

// ==== hdl/prog_ram.sv ====
`timescale 1ns/1ps

// Program and data memory of one tile
// Port a carries instruction fetch, port b carries data load and store
module prog_ram (
	input  logic                               clk,
	input  logic                               reset,

	//************************************************************
	// Slave port a, instruction fetch
	//************************************************************
	input  logic [tile_mem_pkg::DATA_WIDTH-1:0] sa_dat_i,  // Write data
	input  logic [tile_mem_pkg::SEL_WIDTH-1:0]  sa_sel_i,  // Byte selects
	input  logic [tile_mem_pkg::ADDR_WIDTH-1:0] sa_addr_i, // Word address
	input  tile_mem_pkg::cti_e                 sa_cti_i,  // Classic or burst
	input  logic                               sa_stb_i,  // Strobe
	input  logic                               sa_we_i,   // Write enable
	output logic [tile_mem_pkg::DATA_WIDTH-1:0] sa_dat_o,  // Read data
	output logic                               sa_ack_o,  // Acknowledge

	//************************************************************
	// Slave port b, data load and store
	//************************************************************
	input  logic [tile_mem_pkg::DATA_WIDTH-1:0] sb_dat_i,
	input  logic [tile_mem_pkg::SEL_WIDTH-1:0]  sb_sel_i,
	input  logic [tile_mem_pkg::ADDR_WIDTH-1:0] sb_addr_i,
	input  tile_mem_pkg::cti_e                 sb_cti_i,
	input  logic                               sb_stb_i,
	input  logic                               sb_we_i,
	output logic [tile_mem_pkg::DATA_WIDTH-1:0] sb_dat_o,
	output logic                               sb_ack_o
);
	import tile_mem_pkg::*;

	// Side a of the array
	logic                  we_a;   // Strobed write enable
	logic [SEL_WIDTH-1:0]  be_a;   // Byte mask
	logic [ADDR_WIDTH-1:0] addr_a; // Word address
	logic [DATA_WIDTH-1:0] data_a; // Write data
	logic [DATA_WIDTH-1:0] q_a;    // Registered read data

	// Side b of the array
	logic                  we_b;
	logic [SEL_WIDTH-1:0]  be_b;
	logic [ADDR_WIDTH-1:0] addr_b;
	logic [DATA_WIDTH-1:0] data_b;
	logic [DATA_WIDTH-1:0] q_b;

	bus_slave_port port_a_i ( // Instruction side
		.clk        (clk),
		.reset      (reset),
		.dat_i      (sa_dat_i),
		.sel_i      (sa_sel_i),
		.addr_i     (sa_addr_i),
		.cti_i      (sa_cti_i),
		.stb_i      (sa_stb_i),
		.we_i       (sa_we_i),
		.dat_o      (sa_dat_o),
		.ack_o      (sa_ack_o),
		.ram_we_o   (we_a),
		.ram_be_o   (be_a),
		.ram_addr_o (addr_a),
		.ram_data_o (data_a),
		.ram_q_i    (q_a)
	);

	bus_slave_port port_b_i ( // Data side
		.clk        (clk),
		.reset      (reset),
		.dat_i      (sb_dat_i),
		.sel_i      (sb_sel_i),
		.addr_i     (sb_addr_i),
		.cti_i      (sb_cti_i),
		.stb_i      (sb_stb_i),
		.we_i       (sb_we_i),
		.dat_o      (sb_dat_o),
		.ack_o      (sb_ack_o),
		.ram_we_o   (we_b),
		.ram_be_o   (be_b),
		.ram_addr_o (addr_b),
		.ram_data_o (data_b),
		.ram_q_i    (q_b)
	);

	// Shared array, port a wins a write collision
	dual_port_ram ram_i (
		.clk      (clk),
		.we_a_i   (we_a),
		.be_a_i   (be_a),
		.addr_a_i (addr_a),
		.data_a_i (data_a),
		.q_a_o    (q_a),
		.we_b_i   (we_b),
		.be_b_i   (be_b),
		.addr_b_i (addr_b),
		.data_b_i (data_b),
		.q_b_o    (q_b)
	);

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps

// Clock and reset for the testbench
module tb_clock_gen (
	output logic clk_o,   // 20 ns clock
	output logic reset_o  // Active high, synchronous to clk_o
);

	initial begin
		clk_o = 1'b0;
		forever begin
			#10 clk_o = ~clk_o; // Half period
		end
	end

	initial begin
		reset_o = 1'b1;               // Held over the first two rising edges
		repeat (2) @(posedge clk_o);
		reset_o <= 1'b0;              // Drops just after the second edge
	end

endmodule

// ==== tests/prog_ram_tb.sv ====
`timescale 1ns/1ps

module prog_ram_tb;
	import tile_mem_pkg::*;

	localparam int ACK_TIMEOUT   = 8;  // Cycles allowed for a classic ack
	localparam int RESET_TIMEOUT = 10; // Cycles allowed for reset release

	logic clk;
	logic reset;

	// Port a master
	logic [DATA_WIDTH-1:0] sa_dat;
	logic [SEL_WIDTH-1:0]  sa_sel;
	logic [ADDR_WIDTH-1:0] sa_addr;
	cti_e                  sa_cti;
	logic                  sa_stb;
	logic                  sa_we;
	logic [DATA_WIDTH-1:0] sa_rdata;
	logic                  sa_ack;
	// Port b master
	logic [DATA_WIDTH-1:0] sb_dat;
	logic [SEL_WIDTH-1:0]  sb_sel;
	logic [ADDR_WIDTH-1:0] sb_addr;
	cti_e                  sb_cti;
	logic                  sb_stb;
	logic                  sb_we;
	logic [DATA_WIDTH-1:0] sb_rdata;
	logic                  sb_ack;

	//************************************************************
	// Reference model state
	//************************************************************
	logic [DATA_WIDTH-1:0] model_mem [0:MEM_DEPTH-1];
	logic [DATA_WIDTH-1:0] exp_q_a;       // Word read at the last edge
	logic [DATA_WIDTH-1:0] exp_q_b;
	logic                  exp_ack_reg_a; // Classic ack register
	logic                  exp_ack_reg_b;

	int errors;
	int timeouts;

	tb_clock_gen clk_gen_i (.clk_o(clk), .reset_o(reset));

	prog_ram dut_i (
		.clk (clk), .reset (reset),
		.sa_dat_i (sa_dat), .sa_sel_i (sa_sel), .sa_addr_i (sa_addr), .sa_cti_i (sa_cti),
		.sa_stb_i (sa_stb), .sa_we_i (sa_we), .sa_dat_o (sa_rdata), .sa_ack_o (sa_ack),
		.sb_dat_i (sb_dat), .sb_sel_i (sb_sel), .sb_addr_i (sb_addr), .sb_cti_i (sb_cti),
		.sb_stb_i (sb_stb), .sb_we_i (sb_we), .sb_dat_o (sb_rdata), .sb_ack_o (sb_ack)
	);

	task automatic check_value(input logic [DATA_WIDTH-1:0] got,
			input logic [DATA_WIDTH-1:0] exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Selected bytes of the new word over the old one
	function automatic logic [DATA_WIDTH-1:0] merge_bytes(input logic [DATA_WIDTH-1:0] old_w,
			input logic [DATA_WIDTH-1:0] new_w, input logic [SEL_WIDTH-1:0] sel);
		logic [DATA_WIDTH-1:0] res;
		res = old_w;
		for (int i = 0; i < SEL_WIDTH; i++) begin
			if (sel[i]) begin
				res[i*BYTE_WIDTH +: BYTE_WIDTH] = new_w[i*BYTE_WIDTH +: BYTE_WIDTH];
			end
		end
		return res;
	endfunction

	function automatic logic ack_expected(input cti_e cti, input logic ack_reg, input logic stb);
		return (cti == CTI_CLASSIC) ? ack_reg : stb; // Registered or pass-through
	endfunction

	function automatic logic [ADDR_WIDTH-1:0] rand_addr();
		logic [31:0] r;
		r = $urandom();
		return r[ADDR_WIDTH-1:0];
	endfunction

	function automatic logic [SEL_WIDTH-1:0] rand_sel();
		logic [31:0] r;
		r = $urandom();
		return r[SEL_WIDTH-1:0];
	endfunction

	function automatic logic [DATA_WIDTH-1:0] rand_word();
		return $urandom();
	endfunction

	function automatic logic rand_bit();
		logic [31:0] r;
		r = $urandom();
		return r[0];
	endfunction

	function automatic cti_e rand_burst_tag();
		logic [31:0] r;
		r = $urandom();
		case (r[1:0])
			2'd0:    return CTI_CONST_BURST;
			2'd1:    return CTI_INC_BURST;
			default: return CTI_END_BURST;
		endcase
	endfunction

	task automatic drive_a(input logic we, input logic [ADDR_WIDTH-1:0] addr,
			input logic [DATA_WIDTH-1:0] dat, input logic [SEL_WIDTH-1:0] sel);
		sa_we   = we;
		sa_addr = addr;
		sa_dat  = dat;
		sa_sel  = sel;
	endtask

	task automatic drive_b(input logic we, input logic [ADDR_WIDTH-1:0] addr,
			input logic [DATA_WIDTH-1:0] dat, input logic [SEL_WIDTH-1:0] sel);
		sb_we   = we;
		sb_addr = addr;
		sb_dat  = dat;
		sb_sel  = sel;
	endtask

	//************************************************************
	// One clock of model update, edge and compare at the falling edge
	//************************************************************
	task automatic step_cycle();
		logic ack_now_a;
		logic ack_now_b;
		ack_now_a = ack_expected(sa_cti, exp_ack_reg_a, sa_stb);
		ack_now_b = ack_expected(sb_cti, exp_ack_reg_b, sb_stb);
		exp_q_a = model_mem[sa_addr]; // Read-first
		exp_q_b = model_mem[sb_addr];
		exp_ack_reg_a = reset ? 1'b0 : (sa_stb & ~ack_now_a);
		exp_ack_reg_b = reset ? 1'b0 : (sb_stb & ~ack_now_b);
		if (sb_stb && sb_we) begin
			model_mem[sb_addr] = merge_bytes(model_mem[sb_addr], sb_dat, sb_sel);
		end
		if (sa_stb && sa_we) begin // Applied last so port a wins
			model_mem[sa_addr] = merge_bytes(model_mem[sa_addr], sa_dat, sa_sel);
		end
		@(posedge clk);
		@(negedge clk);
		check_value(sa_rdata, exp_q_a, "port a read data");
		check_value(sb_rdata, exp_q_b, "port b read data");
		check_value({31'd0, sa_ack}, {31'd0, ack_expected(sa_cti, exp_ack_reg_a, sa_stb)},
			"port a ack");
		check_value({31'd0, sb_ack}, {31'd0, ack_expected(sb_cti, exp_ack_reg_b, sb_stb)},
			"port b ack");
	endtask

	// Classic transfer on the chosen ports that returns in the ack cycle
	task automatic classic_pair(input logic use_a, input logic use_b);
		int n;
		logic done_a;
		logic done_b;
		sa_stb = 1'b0;
		sb_stb = 1'b0;
		sa_cti = CTI_CLASSIC;
		sb_cti = CTI_CLASSIC;
		step_cycle(); // Idle cycle brings the ack register back to low
		done_a = ~use_a;
		done_b = ~use_b;
		sa_stb = use_a;
		sb_stb = use_b;
		n = 0;
		while (!(done_a && done_b) && n < ACK_TIMEOUT) begin
			step_cycle();
			n++;
			if (sa_stb && sa_ack) begin
				done_a = 1'b1;
				sa_stb = 1'b0; // Transfer complete
			end
			if (sb_stb && sb_ack) begin
				done_b = 1'b1;
				sb_stb = 1'b0;
			end
		end
		if (!done_a) begin
			timeouts++;
			sa_stb = 1'b0;
			$display("Timeout at %0t ns: port a acknowledge never came", $time);
		end
		if (!done_b) begin
			timeouts++;
			sb_stb = 1'b0;
			$display("Timeout at %0t ns: port b acknowledge never came", $time);
		end
	endtask

	initial begin
		logic [ADDR_WIDTH-1:0] addr_w_a;
		logic [ADDR_WIDTH-1:0] addr_w_b;
		int n;
		errors   = 0;
		timeouts = 0;
		void'($urandom(32'h464e6c0d)); // Fixed seed
		drive_a(1'b0, '0, '0, '0);
		drive_b(1'b0, '0, '0, '0);
		sa_stb = 1'b1; // Held through reset and never acknowledged
		sb_stb = 1'b1;
		sa_cti = CTI_CLASSIC;
		sb_cti = CTI_CLASSIC;
		for (int w = 0; w < MEM_DEPTH; w++) begin
			model_mem[w] = '0;
		end
		$readmemh(INIT_FILE, model_mem); // Same image as the RAM
		exp_ack_reg_a = 1'b0;
		exp_ack_reg_b = 1'b0;

		@(negedge clk);
		n = 0;
		while (reset && n < RESET_TIMEOUT) begin
			check_value({31'd0, sa_ack}, 32'd0, "port a ack during reset");
			check_value({31'd0, sb_ack}, 32'd0, "port b ack during reset");
			@(negedge clk);
			n++;
		end
		if (reset) begin
			timeouts++;
			$display("Timeout: reset was never released");
		end
		check_value({31'd0, sa_ack}, 32'd0, "port a ack after reset");
		check_value({31'd0, sb_ack}, 32'd0, "port b ack after reset");
		sa_stb = 1'b0;
		sb_stb = 1'b0;

		//************************************************************
		// Preload and unloaded words
		//************************************************************
		for (int i = 0; i < 16; i++) begin
			drive_a(1'b0, ADDR_WIDTH'(i), '0, '0);
			drive_b(1'b0, ADDR_WIDTH'(15 - i), '0, '0); // Opposite order on b
			classic_pair(1'b1, 1'b1);
		end
		drive_a(1'b0, 10'd1000, '0, '0);
		drive_b(1'b0, 10'd1023, '0, '0);
		classic_pair(1'b1, 1'b1);
		check_value(sa_rdata, 32'd0, "port a unloaded word");
		check_value(sb_rdata, 32'd0, "port b unloaded word");

		// Held strobe gives an ack on every odd cycle
		drive_a(1'b0, 10'd5, '0, '0);
		drive_b(1'b0, 10'd9, '0, '0);
		step_cycle();
		sa_stb = 1'b1;
		sb_stb = 1'b1;
		for (int k = 1; k <= 6; k++) begin
			step_cycle();
			check_value({31'd0, sa_ack}, {31'd0, k % 2 == 1}, "port a ack under held strobe");
			check_value({31'd0, sb_ack}, {31'd0, k % 2 == 1}, "port b ack under held strobe");
		end
		sa_stb = 1'b0;
		sb_stb = 1'b0;

		// Random byte writes read back crosswise
		for (int t = 0; t < 20; t++) begin
			addr_w_a = rand_addr();
			addr_w_b = rand_addr();
			drive_a(1'b1, addr_w_a, rand_word(), rand_sel());
			drive_b(1'b1, addr_w_b, rand_word(), rand_sel());
			classic_pair(1'b1, 1'b1);
			drive_a(1'b0, addr_w_b, '0, '0);
			drive_b(1'b0, addr_w_a, '0, '0);
			classic_pair(1'b1, 1'b1);
		end

		//************************************************************
		// Burst cycles with a new address every beat
		//************************************************************
		for (int t = 0; t < 40; t++) begin
			drive_a(rand_bit(), rand_addr(), rand_word(), rand_sel());
			drive_b(rand_bit(), rand_addr(), rand_word(), rand_sel());
			sa_stb = rand_bit() | rand_bit(); // Mostly busy
			sb_stb = rand_bit() | rand_bit();
			sa_cti = rand_burst_tag();
			sb_cti = rand_burst_tag();
			step_cycle();
			check_value({31'd0, sa_ack}, {31'd0, sa_stb}, "port a burst ack vs strobe");
			check_value({31'd0, sb_ack}, {31'd0, sb_stb}, "port b burst ack vs strobe");
		end
		sa_stb = 1'b0;
		sb_stb = 1'b0;
		sa_cti = CTI_CLASSIC;
		sb_cti = CTI_CLASSIC;
		step_cycle();

		// Same-address writes where port a owns shared bytes
		drive_a(1'b1, 10'd200, 32'h11223344, 4'hf);
		classic_pair(1'b1, 1'b0);
		drive_a(1'b1, 10'd200, 32'haaaaaaaa, 4'b0011);
		drive_b(1'b1, 10'd200, 32'hbbbbbbbb, 4'b0110);
		classic_pair(1'b1, 1'b1);
		drive_a(1'b0, 10'd200, '0, '0);
		classic_pair(1'b1, 1'b0);
		check_value(sa_rdata, 32'h11bbaaaa, "collision byte merge");
		for (int t = 0; t < 10; t++) begin
			addr_w_a = rand_addr();
			drive_a(1'b1, addr_w_a, rand_word(), rand_sel());
			drive_b(1'b1, addr_w_a, rand_word(), rand_sel());
			classic_pair(1'b1, 1'b1);
			drive_a(1'b0, addr_w_a, '0, '0);
			drive_b(1'b0, addr_w_a, '0, '0);
			classic_pair(1'b1, 1'b1);
		end

		// Read on one port while the other writes
		drive_a(1'b1, 10'd300, 32'h0badf00d, 4'hf);
		classic_pair(1'b1, 1'b0);
		drive_a(1'b1, 10'd300, 32'hcafe1234, 4'hf);
		drive_b(1'b0, 10'd300, '0, '0);
		classic_pair(1'b1, 1'b1);
		check_value(sb_rdata, 32'h0badf00d, "port b read during port a write");
		drive_a(1'b0, 10'd300, '0, '0);
		drive_b(1'b1, 10'd300, 32'h5a5a5a5a, 4'hf);
		classic_pair(1'b1, 1'b1);
		check_value(sa_rdata, 32'hcafe1234, "port a read during port b write");
		drive_b(1'b0, 10'd300, '0, '0);
		classic_pair(1'b0, 1'b1);
		check_value(sb_rdata, 32'h5a5a5a5a, "word after port b write");

		$display("Mismatches: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== tests/prog_ram_init.hex ====
// Program image, one 32-bit word per line in hex
// Line n after these comments holds the word at address n, from 0 to 15
00000013
00100093
00200113
002081b3
40118233
0041f2b3
0051e333
00c00393
00038463
fff38393
ff9ff06f
00302023
00002403
deadbeef
0badc0de
a5a55a5a

// ==== prog_ram.f ====
hdl/tile_mem_pkg.sv
hdl/dual_port_ram.sv
hdl/bus_slave_port.sv
hdl/prog_ram.sv
tests/tb_clock_gen.sv
tests/prog_ram_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the prog_ram testbench with Verilator and run it.
# Exit status is 0 only when the run ends without the fail message.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot enter the project root"
	exit 1
fi

ROOT_DIR="$(pwd)"
BUILD_DIR="obj_dir"
SIM_BIN="prog_ram_tb_sim"
LOG_FILE="${ROOT_DIR}/sim.log"

verilator --binary --timing --timescale 1ns/1ps \
	--top-module prog_ram_tb \
	-f prog_ram.f \
	--Mdir "${BUILD_DIR}" -o "${SIM_BIN}"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

# The preload image is opened by its bare name, so the run starts in tests/
cd tests
if [ $? -ne 0 ]; then
	echo "Cannot enter tests/"
	exit 1
fi
"${ROOT_DIR}/${BUILD_DIR}/${SIM_BIN}" > "${LOG_FILE}" 2>&1
SIM_STATUS=$?
cd "${ROOT_DIR}"

cat "${LOG_FILE}"
if [ ${SIM_STATUS} -ne 0 ]; then
	echo "Simulation exited with status ${SIM_STATUS}"
	exit 1
fi

if grep -q "Checks failed" "${LOG_FILE}"; then
	exit 1
fi
exit 0
